// File: Bender.yml
package:
  name: coh_mem

sources:
  - cpu_types_pkg.sv
  - coh_bus_pkg.sv
  - bus_control.sv
  - memory_control.sv
  - ram_model.sv
  - coh_mem_top.sv
  - target: test
    files:
      - coh_mem_tb.sv

// File: bus_control.sv
//==========================================================================
// round-robin arbiter for the two cores' data ports; forwards the owner's
// request to the memory controller and strobes a write invalidate to the
// other core when a store completes
//==========================================================================
`default_nettype none

module bus_control
    import cpu_types_pkg::*;
    import coh_bus_pkg::*;
(
    input  logic      CLK,
    input  logic      nRST,
    input  core_req_t core_req  [CPUS],
    output mem_bus_t  dport_rsp [CPUS],
    output bus_mem_t  bmif_out,
    input  mem_bus_t  bmif_in,
    output snoop_t    snoop     [CPUS]
);

    // registered owner and its neighbour
    cpuid_t owner;
    cpuid_t other;
    // combinational grant for this cycle
    cpuid_t gnt;

    logic owner_pend;
    logic other_pend;
    logic gnt_pend;
    // granted transfer finishes this cycle
    logic done;

    assign other = ~owner;

    always_comb begin
        owner_pend = core_req[owner].dREN || core_req[owner].dWEN;
        other_pend = core_req[other].dREN || core_req[other].dWEN;
        // owner keeps the bus while it asks
        // idle owner hands over to a waiting neighbour
        gnt = (!owner_pend && other_pend) ? other : owner;
        gnt_pend = owner_pend || other_pend;
        done = gnt_pend && !bmif_in.dwait;
    end

    // forward the granted request
    always_comb begin
        bmif_out = '0;
        if (gnt_pend) begin
            bmif_out.dREN = core_req[gnt].dREN;
            bmif_out.dWEN = core_req[gnt].dWEN;
            bmif_out.daddr = core_req[gnt].daddr;
            bmif_out.dstore = core_req[gnt].dstore;
        end
    end

    // answer goes to the granted core only
    always_comb begin
        for (int i = 0; i < CPUS; i++) begin
            dport_rsp[i].dwait = 1'b1;
            dport_rsp[i].dload = '0;
            if (gnt == cpuid_t'(i)) begin
                dport_rsp[i].dwait = bmif_in.dwait;
                dport_rsp[i].dload = bmif_in.dload;
            end
        end
    end

    // write invalidate to every core but the writer
    always_comb begin
        for (int i = 0; i < CPUS; i++) begin
            snoop[i].inv = 1'b0;
            snoop[i].addr = '0;
            if (gnt != cpuid_t'(i)) begin
                snoop[i].inv = done && bmif_out.dWEN;
                snoop[i].addr = bmif_out.daddr;
            end
        end
    end

    // owner follows the grant
    // flips after each completed transfer so contenders alternate
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            owner <= '0;
        end else if (done) begin
            owner <= ~gnt;
        end else begin
            owner <= gnt;
        end
    end

    // only one core can be the target of a store invalidate
    assert property (@(posedge CLK) disable iff (!nRST)
        !(snoop[0].inv && snoop[1].inv));

endmodule : bus_control

`default_nettype wire

// File: coh_bus_pkg.sv
//==========================================================================
// request and response bundles for core ports, the bus to memory link,
// snoop strobes and the ram command; import next to cpu_types_pkg
//==========================================================================
`default_nettype none

package coh_bus_pkg;
    import cpu_types_pkg::*;

    // one core's request, instruction half then data half
    typedef struct packed {
        logic  iREN;
        addr_t iaddr;
        logic  dREN;
        logic  dWEN;
        addr_t daddr;
        word_t dstore;
    } core_req_t;

    // one core's response
    typedef struct packed {
        logic  iwait;
        word_t iload;
        logic  dwait;
        word_t dload;
    } core_rsp_t;

    // granted data request out of the bus controller
    typedef struct packed {
        logic  dREN;
        logic  dWEN;
        addr_t daddr;
        word_t dstore;
    } bus_mem_t;

    // memory controller answer for the granted data request
    typedef struct packed {
        logic  dwait;
        word_t dload;
    } mem_bus_t;

    // single-cycle invalidate plus the written address
    typedef struct packed {
        logic  inv;
        addr_t addr;
    } snoop_t;

    // ram command and status
    typedef struct packed {
        logic  ren;
        logic  wen;
        addr_t addr;
        word_t store;
    } ram_req_t;

    typedef struct packed {
        ramstate_t state;
        word_t     load;
    } ram_rsp_t;

endpackage : coh_bus_pkg

`default_nettype wire

// File: coh_mem.f
cpu_types_pkg.sv
coh_bus_pkg.sv
bus_control.sv
memory_control.sv
ram_model.sv
coh_mem_top.sv
coh_mem_tb.sv

// File: coh_mem_patterns.txt
# per core: kind addr store expect, core 0 then core 1, all values in hex
# kind N none, I fetch, R data read, W data write; expect unused for N and W
R 00000040 00000000 00000010 N 00000000 00000000 00000000
N 00000000 00000000 00000000 R 00000084 00000000 00000021
I 00000100 00000000 00000040 N 00000000 00000000 00000000
N 00000000 00000000 00000000 I 00000104 00000000 00000041
W 00000200 cafef00d 00000000 N 00000000 00000000 00000000
R 00000200 00000000 cafef00d N 00000000 00000000 00000000
N 00000000 00000000 00000000 R 00000200 00000000 cafef00d
I 00000200 00000000 cafef00d N 00000000 00000000 00000000
N 00000000 00000000 00000000 I 00000200 00000000 cafef00d
N 00000000 00000000 00000000 W 00000300 12345678 00000000
R 00000300 00000000 12345678 R 00000304 00000000 000000c1
W 00000400 aaaa5555 00000000 W 00000404 5555aaaa 00000000
R 00000404 00000000 5555aaaa R 00000400 00000000 aaaa5555
I 00000010 00000000 00000004 R 00000020 00000000 00000008
R 00000030 00000000 0000000c I 00000014 00000000 00000005
I 00000044 00000000 00000011 I 00000048 00000000 00000012
W 00000500 0badc0de 00000000 R 00000504 00000000 00000141
R 00000508 00000000 00000142 W 00000500 feedface 00000000
I 00000500 00000000 feedface I 00000200 00000000 cafef00d
W 00000ffc 11112222 00000000 N 00000000 00000000 00000000
N 00000000 00000000 00000000 R 00000ffc 00000000 11112222
R 00000003 00000000 00000000 I 00000202 00000000 cafef00d

// File: coh_mem_tb.sv
//==========================================================================
// testbench for the dual-core memory subsystem; replays the groups from
// the pattern file on both cores, checks loads, latency and snoops
//==========================================================================
`default_nettype none

module coh_mem_tb
    import cpu_types_pkg::*;
    import coh_bus_pkg::*;
();

    localparam int LAT     = 3;
    localparam int DEPTH_W = 10;

    // one port's transfer as read from the pattern file
    typedef struct packed {
        logic [7:0] kind;
        addr_t      addr;
        word_t      store;
        word_t      exp_load;
    } op_t;

    // one observed invalidate
    typedef struct packed {
        cpuid_t core;
        addr_t  addr;
    } inv_rec_t;

    localparam op_t NO_OP = '{kind: "N", addr: '0, store: '0, exp_load: '0};

    logic      CLK = 1'b0;
    logic      nRST;
    core_req_t core_req [CPUS];
    core_rsp_t core_rsp [CPUS];
    snoop_t    snoop    [CPUS];

    // two entries per group, core 0 first
    op_t      ops [$];
    inv_rec_t inv_log [$];
    // words written so far, keyed by word index
    word_t    model_mem [int];
    int       errors = 0;
    int       n_groups = 0;
    logic     loaded = 1'b0;

    coh_mem_top #(
        .LAT     (LAT),
        .DEPTH_W (DEPTH_W)
    ) dut (
        .CLK      (CLK),
        .nRST     (nRST),
        .core_req (core_req),
        .core_rsp (core_rsp),
        .snoop    (snoop)
    );

    always #2 CLK = ~CLK;

    // invalidates sampled mid-cycle
    always @(negedge CLK) begin
        for (int i = 0; i < CPUS; i++) begin
            if (nRST && snoop[i].inv) begin
                inv_log.push_back('{cpuid_t'(i), snoop[i].addr});
            end
        end
    end

    // unwritten words hold their own word index
    function automatic word_t model_read(input addr_t a);
        int idx;
        idx = int'(a[DEPTH_W+1:2]);
        if (model_mem.exists(idx)) begin
            return model_mem[idx];
        end
        return word_t'(idx);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            errors++;
            $display("[ERROR] t=%0t %s got %h expected %h", $time, name, got, want);
        end
    endtask

    // hold the request until wait drops, drop it on the next edge
    task automatic run_port(input int c, input op_t op, output int cycles,
                            output word_t load);
        logic done;
        cycles = 0;
        load = '0;
        done = (op.kind == "N");
        if (op.kind == "I") begin
            core_req[c].iREN <= 1'b1;
            core_req[c].iaddr <= op.addr;
        end else if (!done) begin
            core_req[c].dREN <= (op.kind == "R");
            core_req[c].dWEN <= (op.kind == "W");
            core_req[c].daddr <= op.addr;
            core_req[c].dstore <= op.store;
        end
        while (!done) begin
            @(negedge CLK);
            cycles++;
            if (op.kind == "I" && !core_rsp[c].iwait) begin
                done = 1'b1;
                load = core_rsp[c].iload;
            end else if (op.kind != "I" && !core_rsp[c].dwait) begin
                done = 1'b1;
                load = core_rsp[c].dload;
            end
        end
        // only this port lets go, the core's other port may still be busy
        if (op.kind == "I") begin
            @(posedge CLK);
            core_req[c].iREN <= 1'b0;
        end else if (op.kind != "N") begin
            @(posedge CLK);
            core_req[c].dREN <= 1'b0;
            core_req[c].dWEN <= 1'b0;
        end
    endtask

    task automatic check_port(input int c, input op_t op, input logic alone,
                              input word_t pred, input int cycles, input word_t load);
        if (op.kind != "N") begin
            // lone transfer takes exactly the ram latency
            // contended one waits for at most one other access
            if (alone) begin
                check_value($sformatf("core%0d latency", c), cycles, LAT);
            end else begin
                check_value($sformatf("core%0d within 2*LAT", c), cycles <= 2 * LAT, 1'b1);
            end
            if (op.kind != "W") begin
                check_value($sformatf("pattern expect core%0d", c), op.exp_load, pred);
                check_value($sformatf("core_rsp[%0d].%s", c, op.kind == "I" ? "iload" : "dload"),
                            load, pred);
            end
        end
    endtask

    // a store pulses the other core once, never the writer
    task automatic check_snoops(input op_t op0, input op_t op1);
        int  cnt [CPUS] = '{default: 0};
        op_t wr;
        foreach (inv_log[k]) begin
            wr = inv_log[k].core ? op0 : op1;
            cnt[inv_log[k].core]++;
            check_value($sformatf("snoop[%0d].addr", inv_log[k].core), inv_log[k].addr, wr.addr);
        end
        check_value("snoop[0] pulses", cnt[0], op1.kind == "W");
        check_value("snoop[1] pulses", cnt[1], op0.kind == "W");
        inv_log.delete();
    endtask

    // fetch held against two queued data reads, one per core
    // fairness lets it in right after the first data access
    task automatic fetch_under_load();
        op_t   fop;
        op_t   dop0;
        op_t   dop1;
        int    cyc_f;
        int    cyc_d0;
        int    cyc_d1;
        word_t load_f;
        word_t load_d0;
        word_t load_d1;
        fop = '{kind: "I", addr: 32'h0000_0600, store: '0, exp_load: '0};
        dop0 = '{kind: "R", addr: 32'h0000_0604, store: '0, exp_load: '0};
        dop1 = '{kind: "R", addr: 32'h0000_0608, store: '0, exp_load: '0};
        @(posedge CLK);
        fork
            run_port(0, fop, cyc_f, load_f);
            run_port(0, dop0, cyc_d0, load_d0);
            run_port(1, dop1, cyc_d1, load_d1);
        join
        check_value("core0 fetch under data load within 2*LAT", cyc_f <= 2 * LAT, 1'b1);
        check_value("core_rsp[0].iload", load_f, model_read(fop.addr));
        check_value("core_rsp[0].dload", load_d0, model_read(dop0.addr));
        check_value("core_rsp[1].dload", load_d1, model_read(dop1.addr));
        check_snoops(NO_OP, NO_OP);
    endtask

    initial begin : main
        int               fd;
        int               n;
        int               line_no;
        logic [8*128-1:0] line;
        logic [31:0]      f [8];
        op_t              op0;
        op_t              op1;
        word_t            pred0;
        word_t            pred1;
        word_t            load0;
        word_t            load1;
        int               cyc0;
        int               cyc1;
        nRST = 1'b0;
        line_no = 0;
        for (int i = 0; i < CPUS; i++) begin
            core_req[i] = '0;
        end
        fd = $fopen("coh_mem_patterns.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("pattern file coh_mem_patterns.txt could not be opened");
        end
        while (fd != 0 && $fgets(line, fd) > 0) begin
            line_no++;
            n = $sscanf(line, "%s %h %h %h %s %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
            if (n == 8 && f[0][7:0] != "#") begin
                ops.push_back('{f[0][7:0], f[1], f[2], f[3]});
                ops.push_back('{f[4][7:0], f[5], f[6], f[7]});
            end else if (n > 0 && f[0][7:0] != "#") begin
                errors++;
                $display("pattern line %0d could not be parsed", line_no);
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        n_groups = ops.size() / 2;
        if (n_groups == 0) begin
            errors++;
            $display("no transaction groups were read from the pattern file");
        end
        loaded = 1'b1;

        repeat (10) @(posedge CLK);
        nRST <= 1'b1;
        // idle after reset, all waits high and quiet snoops
        repeat (4) begin
            @(negedge CLK);
            for (int i = 0; i < CPUS; i++) begin
                check_value($sformatf("core_rsp[%0d].iwait", i), core_rsp[i].iwait, 1'b1);
                check_value($sformatf("core_rsp[%0d].dwait", i), core_rsp[i].dwait, 1'b1);
            end
        end
        check_snoops(NO_OP, NO_OP);

        for (int g = 0; g < n_groups; g++) begin
            op0 = ops[2*g];
            op1 = ops[2*g+1];
            // reads never touch a word stored in the same group
            pred0 = model_read(op0.addr);
            pred1 = model_read(op1.addr);
            @(posedge CLK);
            fork
                run_port(0, op0, cyc0, load0);
                run_port(1, op1, cyc1, load1);
            join
            check_port(0, op0, op1.kind == "N", pred0, cyc0, load0);
            check_port(1, op1, op0.kind == "N", pred1, cyc1, load1);
            if (op0.kind == "W") begin
                model_mem[int'(op0.addr[DEPTH_W+1:2])] = op0.store;
            end
            if (op1.kind == "W") begin
                model_mem[int'(op1.addr[DEPTH_W+1:2])] = op1.store;
            end
            check_snoops(op0, op1);
        end

        fetch_under_load();

        $display("coh_mem_tb finished: %0d groups, %0d errors", n_groups, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // run limit grows with the number of groups
    initial begin
        wait (loaded);
        repeat (40 * LAT * (n_groups + 4)) @(posedge CLK);
        $display("watchdog expired, the run did not finish within %0d cycles",
                 40 * LAT * (n_groups + 4));
        $display(">>> FAIL");
        $finish;
    end

endmodule : coh_mem_tb

`default_nettype wire

// File: coh_mem_top.sv
//==========================================================================
// dual-core memory subsystem top; each core connects an instruction and
// a data port, snoop strobes go back out per core
//==========================================================================
`default_nettype none

module coh_mem_top
    import cpu_types_pkg::*;
    import coh_bus_pkg::*;
#(
    // ram latency in cycles, 2 or more
    parameter int LAT     = 3,
    // ram depth as a word address width
    parameter int DEPTH_W = 10
) (
    input  logic      CLK,
    input  logic      nRST,
    input  core_req_t core_req [CPUS],
    output core_rsp_t core_rsp [CPUS],
    output snoop_t    snoop    [CPUS]
);

    // ram command and status between arbiter and array
    ram_req_t ram_req;
    ram_rsp_t ram_rsp;

    // arbitration, data port ownership and snoops
    memory_control u_mem_ctrl (
        .CLK      (CLK),
        .nRST     (nRST),
        .core_req (core_req),
        .core_rsp (core_rsp),
        .snoop    (snoop),
        .ram_req  (ram_req),
        .ram_rsp  (ram_rsp)
    );

    // shared word ram
    ram_model #(
        .LAT     (LAT),
        .DEPTH_W (DEPTH_W)
    ) u_ram (
        .CLK     (CLK),
        .nRST    (nRST),
        .ram_req (ram_req),
        .ram_rsp (ram_rsp)
    );

endmodule : coh_mem_top

`default_nettype wire

// File: cpu_types_pkg.sv
//==========================================================================
// machine word, address and ram state types for the dual-core memory
// subsystem; import wherever words, addresses or ram state are needed
//==========================================================================
`default_nettype none

package cpu_types_pkg;

    // number of cores
    // both arbiters flip a single bit, so this stays at two
    localparam int CPUS = 2;

    // 32-bit data word
    typedef logic [31:0] word_t;

    // byte address
    // ram only looks at the word part
    typedef logic [31:0] addr_t;

    // core index for owners and pointers
    typedef logic [0:0] cpuid_t;

    // ram handshake state
    typedef enum logic [1:0] {
        // no request
        FREE,
        // counting down the access latency
        BUSY,
        // load valid or write done in this cycle
        ACCESS
    } ramstate_t;

endpackage : cpu_types_pkg

`default_nettype wire

// File: memory_control.sv
//==========================================================================
// ram arbiter between the granted data request and the instruction
// fetches of both cores; data goes first, but every data access is
// followed by a fetch slot if one is waiting
//==========================================================================
`default_nettype none

module memory_control
    import cpu_types_pkg::*;
    import coh_bus_pkg::*;
(
    input  logic      CLK,
    input  logic      nRST,
    input  core_req_t core_req [CPUS],
    output core_rsp_t core_rsp [CPUS],
    output snoop_t    snoop    [CPUS],
    output ram_req_t  ram_req,
    input  ram_rsp_t  ram_rsp
);

    // link to the data port arbiter
    bus_mem_t bus_mem;
    mem_bus_t mem_bus;
    mem_bus_t dport_rsp [CPUS];

    // fetch round-robin pointer
    cpuid_t ipick;
    // last ram access served data
    logic data_hit;

    cpuid_t icore;
    logic fetch_pend;
    logic data_pend;
    logic serve_data;
    logic serve_fetch;
    logic access;

    bus_control u_bus_ctrl (
        .CLK       (CLK),
        .nRST      (nRST),
        .core_req  (core_req),
        .dport_rsp (dport_rsp),
        .bmif_out  (bus_mem),
        .bmif_in   (mem_bus),
        .snoop     (snoop)
    );

    always_comb begin
        // skip the pointer when its core has no fetch
        icore = core_req[ipick].iREN ? ipick : ~ipick;
        fetch_pend = core_req[icore].iREN;
        data_pend = bus_mem.dREN || bus_mem.dWEN;
        // data wins unless it just had the ram and a fetch waits
        serve_data = data_pend && !(data_hit && fetch_pend);
        serve_fetch = fetch_pend && !serve_data;
        access = ram_rsp.state == ACCESS;
    end

    // ram command from the winner
    always_comb begin
        ram_req = '0;
        if (serve_data) begin
            ram_req.ren = bus_mem.dREN;
            ram_req.wen = bus_mem.dWEN;
            ram_req.addr = bus_mem.daddr;
            ram_req.store = bus_mem.dstore;
        end else if (serve_fetch) begin
            ram_req.ren = 1'b1;
            ram_req.addr = core_req[icore].iaddr;
        end
    end

    // data answer back to the bus controller
    assign mem_bus.dwait = !(serve_data && access);
    assign mem_bus.dload = ram_rsp.load;

    // per core response, wait drops only for the fetch winner
    always_comb begin
        for (int i = 0; i < CPUS; i++) begin
            core_rsp[i].iwait = 1'b1;
            core_rsp[i].iload = '0;
            core_rsp[i].dwait = dport_rsp[i].dwait;
            core_rsp[i].dload = dport_rsp[i].dload;
            if (serve_fetch && icore == cpuid_t'(i)) begin
                core_rsp[i].iwait = !access;
                core_rsp[i].iload = ram_rsp.load;
            end
        end
    end

    // fairness and pointer move only on a finished access
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            ipick <= '0;
            data_hit <= 1'b0;
        end else if (access) begin
            data_hit <= serve_data;
            if (serve_fetch) begin
                ipick <= ~icore;
            end
        end
    end

    // ram must never report a finished access without a command
    assert property (@(posedge CLK) disable iff (!nRST)
        (ram_rsp.state == ACCESS) |-> (ram_req.ren || ram_req.wen));

endmodule : memory_control

`default_nettype wire

// File: ram_model.sv
//==========================================================================
// single-port word ram with a fixed access latency; words that were never
// written read back as their own word index
//==========================================================================
`default_nettype none

module ram_model
    import cpu_types_pkg::*;
    import coh_bus_pkg::*;
#(
    parameter int LAT     = 3,
    parameter int DEPTH_W = 10
) (
    input  logic     CLK,
    input  logic     nRST,
    input  ram_req_t ram_req,
    output ram_rsp_t ram_rsp
);

    localparam int CNT_W = $clog2(LAT + 1);

    word_t              mem [2**DEPTH_W];
    logic [DEPTH_W-1:0] idx;
    // cycles spent on the current request
    logic [CNT_W-1:0]   count;
    logic [CNT_W-1:0]   count_cur;
    logic               tracking;
    logic               track_wen;
    addr_t              track_addr;
    logic               req_on;
    logic               fresh;

    if (LAT < 2) begin : g_lat_check
        $error("ram_model needs a latency of at least 2");
    end

    // identity pattern at power-up
    initial begin
        for (int i = 0; i < 2**DEPTH_W; i++) begin
            mem[i] = word_t'(i);
        end
    end

    assign req_on = ram_req.ren || ram_req.wen;
    assign idx = ram_req.addr[DEPTH_W+1:2];
    // new word address or new direction restarts the count
    assign fresh = !tracking
                || (ram_req.addr[31:2] != track_addr[31:2])
                || (ram_req.wen != track_wen);
    assign count_cur = fresh ? '0 : count;

    always_comb begin
        if (!req_on) begin
            ram_rsp.state = FREE;
        end else if (count_cur == CNT_W'(LAT - 1)) begin
            ram_rsp.state = ACCESS;
        end else begin
            ram_rsp.state = BUSY;
        end
        ram_rsp.load = mem[idx];
    end

    // latency tracking
    // a request held past ACCESS starts over
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            tracking <= 1'b0;
            track_wen <= 1'b0;
            track_addr <= '0;
            count <= '0;
        end else if (!req_on || ram_rsp.state == ACCESS) begin
            tracking <= 1'b0;
            count <= '0;
        end else begin
            tracking <= 1'b1;
            track_wen <= ram_req.wen;
            track_addr <= ram_req.addr;
            count <= count_cur + 1'b1;
        end
    end

    // store lands in the ACCESS cycle
    always @(posedge CLK) begin
        if (ram_rsp.state == ACCESS && ram_req.wen) begin
            mem[idx] <= ram_req.store;
        end
    end

    assert property (@(posedge CLK) disable iff (!nRST)
        !(ram_req.ren && ram_req.wen));

endmodule : ram_model

`default_nettype wire
